//--- source/smt_mem_pkg.sv
// Shared definitions for the SMT memory-side arbitration and WFI halt logic
// Thread and retire sizing, memory request format, grant and retire types
// Every RTL module and the testbench pull this in by wildcard import
package smt_mem_pkg;

    // ------------------------------
    // Core sizing
    // ------------------------------
    localparam int THREAD_NUM       = 2;    // Hardware threads
    localparam int THREAD_IDX_WIDTH = (THREAD_NUM > 1) ? $clog2(THREAD_NUM) : 1;
    localparam int RT_NUM           = 2;    // Retire slots per thread per cycle
    localparam int XLEN             = 32;   // Address width
    localparam int MEM_DATA_WIDTH   = 64;   // Store data width

    // Requesters sharing the single memory port
    localparam int MEM_PORT_NUM     = 2;
    localparam int MEM_PORT_DATA    = 0;    // LSQ side after thread arbitration
    localparam int MEM_PORT_FETCH   = 1;    // Instruction fetch

    // ------------------------------
    // Memory request
    // ------------------------------

    // NONE marks an idle requester
    typedef enum logic [1:0] {
        MEM_NONE  = 2'b00,
        MEM_LOAD  = 2'b01,
        MEM_STORE = 2'b10
    } mem_cmd_e;

    // Access size in bytes, 1/2/4/8
    typedef enum logic [1:0] {
        MEM_BYTE   = 2'b00,
        MEM_HALF   = 2'b01,
        MEM_WORD   = 2'b10,
        MEM_DOUBLE = 2'b11
    } mem_size_e;

    // 100 bits total
    typedef struct packed {
        mem_cmd_e                   cmd;    // Command
        mem_size_e                  size;   // Access size
        logic [XLEN-1:0]            addr;   // Byte address
        logic [MEM_DATA_WIDTH-1:0]  data;   // Store data, ignored on loads
    } mem_req_t;

    // One bit per thread for grants and dispatch enables
    typedef logic [THREAD_NUM-1:0] thread_mask_t;

    // ------------------------------
    // Retire group
    // ------------------------------

    // Per-slot flags of one thread's retire group
    typedef struct packed {
        logic [RT_NUM-1:0]  valid;  // Slot retires this cycle
        logic [RT_NUM-1:0]  wfi;    // Slot holds a WFI
    } retire_t;

    // Request is live when the command is not NONE
    function automatic logic mem_req_valid(input mem_req_t req);
        return (req.cmd != MEM_NONE);
    endfunction

endpackage

//--- source/mem_req_arbiter.sv
// Round-robin arbiter for memory requests
// Forwards the winning request combinationally and grants it only when the
// downstream side accepts in the same cycle. Priority pointer moves past
// the winner at each accepted grant. Used once per arbitration level.
module mem_req_arbiter
    import smt_mem_pkg::*;
#(
    parameter int REQ_NUM = 2
) (
    input   logic                       clk_i,      // Clock
    input   logic                       reset_i,    // Sync reset, active high
    input   mem_req_t   [REQ_NUM-1:0]   req_i,      // Requests, held until granted
    input   logic                       accept_i,   // Downstream takes req_o now
    output  mem_req_t                   req_o,      // Forwarded winner
    output  logic       [REQ_NUM-1:0]   grant_o     // Single-cycle grant level
);

    localparam int PTR_WIDTH = (REQ_NUM > 1) ? $clog2(REQ_NUM) : 1;

    logic   [REQ_NUM-1:0]       req_valid;      // Live requests
    logic   [PTR_WIDTH-1:0]     rr_ptr;         // Highest priority index
    logic   [PTR_WIDTH-1:0]     ptr_next;       // Slot after the winner
    logic   [PTR_WIDTH-1:0]     winner;         // Selected requester
    logic                       found;          // Any request live

    // ------------------------------
    // Winner selection
    // ------------------------------
    always_comb begin
        for (int i = 0; i < REQ_NUM; i++) begin
            req_valid[i] = mem_req_valid(req_i[i]);
        end
    end

    // Cyclic search starting at the pointer
    always_comb begin : pick_winner
        int idx;
        found  = 1'b0;
        winner = '0;
        for (int off = 0; off < REQ_NUM; off++) begin
            idx = int'(rr_ptr) + off;
            if (idx >= REQ_NUM) begin
                idx = idx - REQ_NUM;        // Wrap around
            end
            if (!found && req_valid[idx]) begin
                found  = 1'b1;
                winner = PTR_WIDTH'(idx);
            end
        end
    end

    // ------------------------------
    // Outputs
    // ------------------------------

    // Winner shown even under back-pressure
    always_comb begin
        req_o     = '0;
        req_o.cmd = MEM_NONE;               // Idle when nobody asks
        if (found) begin
            req_o = req_i[winner];
        end
    end

    // Grant only when downstream accepts
    always_comb begin
        grant_o = '0;
        if (found && accept_i) begin
            grant_o[winner] = 1'b1;
        end
    end

    // ------------------------------
    // Priority pointer
    // ------------------------------
    assign ptr_next = (winner == PTR_WIDTH'(REQ_NUM - 1)) ? '0 : winner + 1'b1;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rr_ptr <= '0;
        end else if (found && accept_i) begin
            rr_ptr <= ptr_next;             // Winner drops to lowest priority
        end                                 // Holds under back-pressure
    end

    // ------------------------------
    // Checks
    // ------------------------------

    // At most one requester consumed per cycle
    a_grant_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0(grant_o))
        else $error("mem_req_arbiter: more than one grant");

    // Never grant an idle requester
    a_grant_valid: assert property (@(posedge clk_i) disable iff (reset_i)
        ((grant_o & ~req_valid) == '0))
        else $error("mem_req_arbiter: grant without request");

    // Back-pressure blocks all grants
    a_grant_accept: assert property (@(posedge clk_i) disable iff (reset_i)
        !accept_i |-> (grant_o == '0))
        else $error("mem_req_arbiter: grant while not accepted");

endmodule

//--- source/wfi_halt_ctrl.sv
// Per-thread halt control for wait-for-interrupt
// A retiring WFI drops that thread's dispatch enable in the same cycle.
// A sticky flag keeps it low until an exception or reset clears it.
module wfi_halt_ctrl
    import smt_mem_pkg::*;
(
    input   logic                           clk_i,          // Clock
    input   logic                           reset_i,        // Sync reset, active high
    input   logic                           exception_i,    // Wakes all threads
    input   retire_t    [THREAD_NUM-1:0]    retire_i,       // Retire groups per thread
    output  thread_mask_t                   dispatch_en_o   // Dispatch allowed
);

    thread_mask_t   wfi_retire;     // WFI retiring this cycle
    thread_mask_t   wfi_flag;       // Thread sits halted

    // ------------------------------
    // Retire event
    // ------------------------------

    // Any slot both valid and WFI
    always_comb begin
        for (int t = 0; t < THREAD_NUM; t++) begin
            wfi_retire[t] = |(retire_i[t].valid & retire_i[t].wfi);
        end
    end

    // ------------------------------
    // Sticky halt flag
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i || exception_i) begin
            wfi_flag <= '0;                     // Exception wins over a new WFI
        end else begin
            wfi_flag <= wfi_flag | wfi_retire;  // Set and hold
        end
    end

    // Drops in the retire cycle already
    assign dispatch_en_o = ~(wfi_retire | wfi_flag);

    // ------------------------------
    // Checks
    // ------------------------------

    // Halt is sticky: a low enable stays low next cycle unless an exception
    // arrives, so a thread with the flag set never dispatches
    a_halt_sticky: assert property (@(posedge clk_i) disable iff (reset_i)
        !exception_i |=> ((dispatch_en_o & ~$past(dispatch_en_o)) == '0))
        else $error("wfi_halt_ctrl: halted thread re-enabled without exception");

endmodule

//--- source/smt_mem_top.sv
// Memory-side plumbing and halt control of a two-thread SMT pipeline
// Thread arbiter picks one LSQ request, the port arbiter then shares the
// single memory port between that winner and instruction fetch.
// Fully combinational from requests to proc2mem_o and grants.
module smt_mem_top
    import smt_mem_pkg::*;
(
    input   logic                           clk_i,          // Clock
    input   logic                           reset_i,        // Sync reset, active high

    // Requesters
    input   mem_req_t   [THREAD_NUM-1:0]    lsq_req_i,      // One per thread LSQ
    input   mem_req_t                       fetch_req_i,    // Instruction fetch
    output  thread_mask_t                   lsq_grant_o,    // LSQ request consumed
    output  logic                           fetch_grant_o,  // Fetch request consumed

    // Memory
    output  mem_req_t                       proc2mem_o,     // Towards memory
    input   logic                           mem_ready_i,    // Memory takes proc2mem_o

    // Halt control
    input   retire_t    [THREAD_NUM-1:0]    retire_i,       // Retire groups
    input   logic                           exception_i,    // Releases WFI halt
    output  thread_mask_t                   dispatch_en_o   // Per-thread dispatch
);

    // ------------------------------
    // Wires
    // ------------------------------
    mem_req_t                           data_req;       // Thread arbiter winner
    logic                               data_accept;    // Port granted data side
    mem_req_t   [MEM_PORT_NUM-1:0]      port_req;       // Port arbiter inputs
    logic       [MEM_PORT_NUM-1:0]      port_grant;     // Port arbiter grants

    assign port_req[MEM_PORT_DATA]  = data_req;
    assign port_req[MEM_PORT_FETCH] = fetch_req_i;

    assign data_accept   = port_grant[MEM_PORT_DATA];
    assign fetch_grant_o = port_grant[MEM_PORT_FETCH];

    // ------------------------------
    // Thread level arbitration
    // ------------------------------
    mem_req_arbiter #(
        .REQ_NUM    (THREAD_NUM)
    ) u_thread_arb (
        .clk_i      (clk_i          ),
        .reset_i    (reset_i        ),
        .req_i      (lsq_req_i      ),
        .accept_i   (data_accept    ),  // Only consumed when the port is won
        .req_o      (data_req       ),
        .grant_o    (lsq_grant_o    )
    );

    // ------------------------------
    // Memory port arbitration
    // ------------------------------
    mem_req_arbiter #(
        .REQ_NUM    (MEM_PORT_NUM)
    ) u_mem_port_arb (
        .clk_i      (clk_i          ),
        .reset_i    (reset_i        ),
        .req_i      (port_req       ),
        .accept_i   (mem_ready_i    ),
        .req_o      (proc2mem_o     ),
        .grant_o    (port_grant     )
    );

    // ------------------------------
    // WFI halt
    // ------------------------------
    wfi_halt_ctrl u_halt (
        .clk_i          (clk_i          ),
        .reset_i        (reset_i        ),
        .exception_i    (exception_i    ),
        .retire_i       (retire_i       ),
        .dispatch_en_o  (dispatch_en_o  )
    );

endmodule

//--- sim/tb_smt_mem_checks.svh
// Compare tasks for the SMT memory top level testbench
// Included inside the testbench module, relies on its abort_test task
`ifndef TB_SMT_MEM_CHECKS_SVH
`define TB_SMT_MEM_CHECKS_SVH

// Idle port only promises a NONE command, other fields are don't care
task automatic check_req(input string name, input mem_req_t exp, input mem_req_t act);
    logic bad;
    if (exp.cmd == MEM_NONE) begin
        bad = (act.cmd !== MEM_NONE);
    end else begin
        bad = (act !== exp);
    end
    if (bad) begin
        $display("[FAIL] %0d ns %s expected %h actual %h", $time, name, exp, act);
        abort_test();
    end
endtask

task automatic check_mask(input string name, input thread_mask_t exp, input thread_mask_t act);
    if (act !== exp) begin
        $display("[FAIL] %0d ns %s expected %b actual %b", $time, name, exp, act);
        abort_test();
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("[FAIL] %0d ns %s expected %b actual %b", $time, name, exp, act);
        abort_test();
    end
endtask

`endif

//--- sim/tb_smt_mem_top.sv
// Testbench for the SMT memory arbitration and WFI halt top level
// One stimulus row per clock, driven on the falling edge; a reference model
// of the round-robin and halt rules predicts every output before the rise
module tb_smt_mem_top
    import smt_mem_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;

    // Retire groups, fields are valid then wfi
    localparam retire_t RT_IDLE  = '{valid: 2'b00, wfi: 2'b00};
    localparam retire_t RT_WFI   = '{valid: 2'b10, wfi: 2'b10};    // Slot 1 retires a WFI
    localparam retire_t RT_NOWFI = '{valid: 2'b01, wfi: 2'b10};    // WFI slot not valid
    localparam retire_t RT_BOTH  = '{valid: 2'b11, wfi: 2'b11};

    typedef struct packed {
        mem_cmd_e   [THREAD_NUM-1:0]    lsq_cmd;
        mem_cmd_e                       fetch_cmd;
        logic                           ready;
        retire_t    [THREAD_NUM-1:0]    retire;
        logic                           exception;
    } row_t;

    logic                           clk_i;
    logic                           reset_i;
    mem_req_t   [THREAD_NUM-1:0]    lsq_req_i;
    mem_req_t                       fetch_req_i;
    thread_mask_t                   lsq_grant_o;
    logic                           fetch_grant_o;
    mem_req_t                       proc2mem_o;
    logic                           mem_ready_i;
    retire_t    [THREAD_NUM-1:0]    retire_i;
    logic                           exception_i;
    thread_mask_t                   dispatch_en_o;

    // ------------------------------
    // Model state
    // ------------------------------
    row_t           rows [$];               // Stimulus table
    mem_req_t       held_req [THREAD_NUM];  // Pending LSQ payloads
    mem_req_t       held_fetch;             // Pending fetch payload
    int             thread_ptr;             // Thread arbiter priority
    int             port_ptr;               // Port arbiter priority
    int             thread_win;
    int             port_win;
    thread_mask_t   halt_flag;
    thread_mask_t   retire_event;
    mem_req_t       exp_req;
    thread_mask_t   exp_lsq_grant;
    logic           exp_fetch_grant;
    thread_mask_t   exp_dispatch;
    int             cycle_count = 0;
    int             cycle_limit;

    smt_mem_top DUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic abort_test();
        $display("*** TEST FAILED ***");
        $fatal(1, "Stopping at the first mismatch");
    endtask

    `include "tb_smt_mem_checks.svh"

    // Fresh payload once the previous one is consumed
    function automatic mem_req_t random_req();
        mem_req_t r;
        r.cmd  = MEM_LOAD;                  // Replaced by the table row
        r.size = mem_size_e'($urandom_range(3));
        r.addr = $urandom;
        r.data = {$urandom, $urandom};
        return r;
    endfunction

    // First valid index at or after ptr, cyclic, -1 when idle
    function automatic int rr_pick(input int n, input logic [31:0] valid, input int ptr);
        int idx;
        for (int off = 0; off < n; off++) begin
            idx = (ptr + off) % n;
            if (valid[idx]) return idx;
        end
        return -1;
    endfunction

    task automatic add_row(input mem_cmd_e l0, input mem_cmd_e l1, input mem_cmd_e f,
                           input logic rdy, input retire_t r0, input retire_t r1,
                           input logic exc);
        row_t row;
        row.lsq_cmd[0] = l0;
        row.lsq_cmd[1] = l1;
        row.fetch_cmd  = f;
        row.ready      = rdy;
        row.retire[0]  = r0;
        row.retire[1]  = r1;
        row.exception  = exc;
        rows.push_back(row);
    endtask

    // ------------------------------
    // Stimulus table
    // ------------------------------
    task automatic build_table();
        add_row(MEM_NONE, MEM_NONE, MEM_NONE, 1'b1, RT_IDLE, RT_IDLE, 1'b0);    // Idle
        add_row(MEM_LOAD, MEM_NONE, MEM_NONE, 1'b1, RT_IDLE, RT_IDLE, 1'b0);    // Thread 0 alone
        add_row(MEM_NONE, MEM_STORE, MEM_NONE, 1'b1, RT_IDLE, RT_IDLE, 1'b0);   // Thread 1 alone
        repeat (4) add_row(MEM_LOAD, MEM_STORE, MEM_NONE, 1'b1, RT_IDLE, RT_IDLE, 1'b0);
        repeat (4) add_row(MEM_LOAD, MEM_NONE, MEM_LOAD, 1'b1, RT_IDLE, RT_IDLE, 1'b0);
        repeat (2) add_row(MEM_LOAD, MEM_STORE, MEM_LOAD, 1'b0, RT_IDLE, RT_IDLE, 1'b0);
        repeat (3) add_row(MEM_LOAD, MEM_STORE, MEM_LOAD, 1'b1, RT_IDLE, RT_IDLE, 1'b0);
        // Halt sequence
        add_row(MEM_NONE, MEM_NONE, MEM_NONE, 1'b1, RT_WFI, RT_IDLE, 1'b0);     // T0 halts
        add_row(MEM_NONE, MEM_NONE, MEM_NONE, 1'b1, RT_IDLE, RT_NOWFI, 1'b0);
        add_row(MEM_LOAD, MEM_NONE, MEM_NONE, 1'b1, RT_IDLE, RT_IDLE, 1'b0);
        add_row(MEM_NONE, MEM_NONE, MEM_NONE, 1'b1, RT_IDLE, RT_IDLE, 1'b1);    // Wake
        add_row(MEM_NONE, MEM_NONE, MEM_NONE, 1'b1, RT_IDLE, RT_BOTH, 1'b1);    // WFI with exc
        add_row(MEM_NONE, MEM_NONE, MEM_NONE, 1'b1, RT_BOTH, RT_WFI, 1'b0);     // Both halt
        repeat (2) add_row(MEM_NONE, MEM_NONE, MEM_NONE, 1'b1, RT_IDLE, RT_IDLE, 1'b0);
        add_row(MEM_NONE, MEM_NONE, MEM_NONE, 1'b1, RT_IDLE, RT_IDLE, 1'b1);
        add_row(MEM_NONE, MEM_NONE, MEM_NONE, 1'b1, RT_IDLE, RT_IDLE, 1'b0);
    endtask

    task automatic drive_row(input row_t row);
        for (int t = 0; t < THREAD_NUM; t++) begin
            lsq_req_i[t]     = held_req[t];
            lsq_req_i[t].cmd = row.lsq_cmd[t];
            retire_i[t]      = row.retire[t];
        end
        fetch_req_i     = held_fetch;
        fetch_req_i.cmd = row.fetch_cmd;
        mem_ready_i     = row.ready;
        exception_i     = row.exception;
    endtask

    // ------------------------------
    // Reference model
    // ------------------------------
    task automatic predict();
        logic [31:0]    tvalid;
        logic [31:0]    pvalid;
        mem_req_t       data_req;
        tvalid = '0;
        for (int t = 0; t < THREAD_NUM; t++) begin
            tvalid[t]       = (lsq_req_i[t].cmd != MEM_NONE);
            retire_event[t] = |(retire_i[t].valid & retire_i[t].wfi);
        end
        thread_win = rr_pick(THREAD_NUM, tvalid, thread_ptr);
        data_req   = '0;
        if (thread_win >= 0) data_req = lsq_req_i[thread_win];
        pvalid                 = '0;
        pvalid[MEM_PORT_DATA]  = (data_req.cmd != MEM_NONE);
        pvalid[MEM_PORT_FETCH] = (fetch_req_i.cmd != MEM_NONE);
        port_win = rr_pick(MEM_PORT_NUM, pvalid, port_ptr);
        exp_req  = '0;
        if (port_win == MEM_PORT_DATA) exp_req = data_req;
        if (port_win == MEM_PORT_FETCH) exp_req = fetch_req_i;
        exp_fetch_grant = mem_ready_i && (port_win == MEM_PORT_FETCH);
        exp_lsq_grant   = '0;
        if (mem_ready_i && port_win == MEM_PORT_DATA) exp_lsq_grant[thread_win] = 1'b1;
        exp_dispatch = ~(retire_event | halt_flag);
    endtask

    // State change at the rising edge
    task automatic advance_model();
        if (port_win >= 0 && mem_ready_i) port_ptr = (port_win + 1) % MEM_PORT_NUM;
        if (exp_lsq_grant != '0) begin
            thread_ptr           = (thread_win + 1) % THREAD_NUM;
            held_req[thread_win] = random_req();
        end
        if (exp_fetch_grant) held_fetch = random_req();
        if (exception_i) halt_flag = '0;
        else halt_flag = halt_flag | retire_event;
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        void'($urandom(32'had96_4a09));
        reset_i     = 1'b1;
        lsq_req_i   = '0;
        fetch_req_i = '0;
        mem_ready_i = 1'b0;
        retire_i    = '0;
        exception_i = 1'b0;
        thread_ptr  = 0;
        port_ptr    = 0;
        halt_flag   = '0;
        for (int t = 0; t < THREAD_NUM; t++) held_req[t] = random_req();
        held_fetch = random_req();
        build_table();
        cycle_limit = RESET_CYCLES + rows.size() + 20;
        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;
        foreach (rows[i]) begin
            drive_row(rows[i]);
            #(CLK_PERIOD / 4);              // Settled, well before the rise
            predict();
            check_req("proc2mem_o", exp_req, proc2mem_o);
            check_mask("lsq_grant_o", exp_lsq_grant, lsq_grant_o);
            check_bit("fetch_grant_o", exp_fetch_grant, fetch_grant_o);
            check_mask("dispatch_en_o", exp_dispatch, dispatch_en_o);
            @(posedge clk_i);
            advance_model();
            @(negedge clk_i);
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

    // Run length guard
    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the run went past %0d clock cycles", cycle_limit);
            $display("*** TEST FAILED ***");
            $fatal(1, "Simulation timed out");
        end
    end

endmodule

//--- sim.f
+incdir+sim
source/smt_mem_pkg.sv
source/mem_req_arbiter.sv
source/wfi_halt_ctrl.sv
source/smt_mem_top.sv
sim/tb_smt_mem_top.sv
